// File: include/pat_defines.svh
`ifndef PAT_DEFINES_SVH
`define PAT_DEFINES_SVH

// ==============================
// core widths
// ==============================

`define PAT_I_WIDTH 20 // one instruction word
`define PAT_D_WIDTH 8 // data path and accumulator
`define PAT_PC_WIDTH 10 // 1024-entry program space

// ==============================
// data memory
// ==============================

`define PAT_DMEM_DEPTH 32
`define PAT_DMEM_ADR_WIDTH 5 // low bits of the i8 immediate

// ==============================
// encoding
// ==============================

// i3 ops carry a 3-bit shift amount in the low nibble
`define PAT_SHAMT_WIDTH 3

// all-ones escape
// selects i3 in the i8 opcode slot and i0 in the i3 sub-opcode slot
`define PAT_PREFIX 4'b1111

`endif

// File: src/pat_isa_pkg.sv
`default_nettype none

package pat_isa_pkg;

`include "pat_defines.svh"

	// i8 view of the word
	typedef struct packed {
		logic [4:0] unused_hi; // former field pointer
		logic [1:0] cond;
		logic unused_fs; // former field select
		logic [3:0] opcode;
		logic [`PAT_D_WIDTH-1:0] imm;
	} i8_t;

	// i3 / i0 view, same upper byte
	typedef struct packed {
		logic [4:0] unused_hi;
		logic [1:0] cond;
		logic unused_fs;
		logic [3:0] prefix; // all ones here
		logic [3:0] sub_op; // i3 op, or all ones for i0
		logic [3:0] low; // shift amount or i0 op
	} short_t;

	typedef union packed {
		i8_t i8;
		short_t short;
	} instr_u;

	// i8 opcodes, 10 and 12 retired
	localparam logic [3:0] OP8_OR = 4'd0;
	localparam logic [3:0] OP8_AND = 4'd1;
	localparam logic [3:0] OP8_ADDM = 4'd2;
	localparam logic [3:0] OP8_SUBM = 4'd3;
	localparam logic [3:0] OP8_ADD = 4'd4;
	localparam logic [3:0] OP8_SUB = 4'd5;
	localparam logic [3:0] OP8_LDI = 4'd6;
	localparam logic [3:0] OP8_LDM = 4'd7;
	localparam logic [3:0] OP8_BF = 4'd8;
	localparam logic [3:0] OP8_BB = 4'd9;
	localparam logic [3:0] OP8_STAM = 4'd11;
	localparam logic [3:0] OP8_ORM = 4'd13;
	localparam logic [3:0] OP8_ANDM = 4'd14;

	// i3 opcodes
	localparam logic [3:0] OP3_SHL = 4'd0;
	localparam logic [3:0] OP3_SHLO = 4'd1;
	localparam logic [3:0] OP3_SHR = 4'd2;
	localparam logic [3:0] OP3_ASR = 4'd3;
	localparam logic [3:0] OP3_IN = 4'd5;
	localparam logic [3:0] OP3_OUT = 4'd8;

	// i0 opcodes
	localparam logic [3:0] OP0_NOT = 4'd0;
	localparam logic [3:0] OP0_TEST = 4'd2;
	localparam logic [3:0] OP0_NOP = 4'd15;

	// condition field, 2 behaves as always
	localparam logic [1:0] COND_ZERO = 2'd0;
	localparam logic [1:0] COND_NEG = 2'd1;
	localparam logic [1:0] COND_ALWAYS = 2'd3;

endpackage

`default_nettype wire

// File: src/pat_uop_pkg.sv
`default_nettype none

package pat_uop_pkg;

	// ALU function, picked in decode
	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT, // ignores operand b
		ALU_SHL,
		ALU_SHLO, // fills with ones
		ALU_SHR,
		ALU_ASR // keeps the sign
	} alu_op_e;

	// what lands in the accumulator
	typedef enum logic [1:0] {
		SRC_ALU,
		SRC_IMM, // operand b, so immediate or memory word
		SRC_IN // external input port
	} res_src_e;

endpackage

`default_nettype wire

// File: src/pat_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

interface pat_exec_if;

	logic valid; // one cycle per instruction
	logic [1:0] cond;
	pat_uop_pkg::alu_op_e alu_op;
	pat_uop_pkg::res_src_e res_src;
	logic operand_mem; // b from data memory, else immediate
	logic [`PAT_D_WIDTH-1:0] imm; // also memory address and branch offset
	logic wr_acc;
	logic wr_mem;
	logic wr_out;
	logic do_test;
	logic br_fwd;
	logic br_back;
	logic taken; // condition result, from execute

	modport decode (
		output valid, cond, alu_op, res_src, operand_mem, imm,
		output wr_acc, wr_mem, wr_out, do_test, br_fwd, br_back
	);

	modport execute (
		input valid, cond, alu_op, res_src, operand_mem, imm,
		input wr_acc, wr_mem, wr_out, do_test, br_fwd, br_back,
		output taken
	);

	// the counter only follows the branch decision
	modport pc (
		input valid, taken, imm, br_fwd, br_back
	);

endinterface

`default_nettype wire

// File: src/pat_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_alu (
	input logic [`PAT_D_WIDTH-1:0] i_a, // accumulator
	input logic [`PAT_D_WIDTH-1:0] i_b, // immediate or memory word
	input pat_uop_pkg::alu_op_e i_op,
	output logic [`PAT_D_WIDTH-1:0] o_y
);

	logic [`PAT_SHAMT_WIDTH-1:0] shamt;
	logic [`PAT_D_WIDTH-1:0] ones_fill;

	assign shamt = i_b[`PAT_SHAMT_WIDTH-1:0]; // shifts look at 3 bits only

	// ones in the positions vacated by a left shift
	assign ones_fill = ~({`PAT_D_WIDTH{1'b1}} << shamt);

	always_comb
	begin
		case (i_op)
			pat_uop_pkg::ALU_OR: o_y = i_a | i_b;
			pat_uop_pkg::ALU_AND: o_y = i_a & i_b;
			pat_uop_pkg::ALU_ADD: o_y = i_a + i_b; // wraps
			pat_uop_pkg::ALU_SUB: o_y = i_a - i_b;
			pat_uop_pkg::ALU_NOT: o_y = ~i_a;
			pat_uop_pkg::ALU_SHL: o_y = i_a << shamt;
			pat_uop_pkg::ALU_SHLO: o_y = (i_a << shamt) | ones_fill;
			pat_uop_pkg::ALU_SHR: o_y = i_a >> shamt;
			pat_uop_pkg::ALU_ASR: o_y = $unsigned($signed(i_a) >>> shamt); // sign in from top
			default: o_y = i_a;
		endcase
	end

endmodule

`default_nettype wire

// File: src/pat_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_data_mem (
	input logic clk,
	input logic [`PAT_DMEM_ADR_WIDTH-1:0] i_rd_adr,
	input logic [`PAT_DMEM_ADR_WIDTH-1:0] i_wr_adr,
	input logic i_wr_en,
	input logic [`PAT_D_WIDTH-1:0] i_wr_data,
	output logic [`PAT_D_WIDTH-1:0] o_rd_data
);

	logic [`PAT_D_WIDTH-1:0] mem [`PAT_DMEM_DEPTH];

	// async read, same cycle as the address
	assign o_rd_data = mem[i_rd_adr];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_adr] <= i_wr_data;
	end

endmodule

`default_nettype wire

// File: src/pat_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_decoder (
	input logic clk,
	input logic reset,
	input logic i_instr_valid,
	input pat_isa_pkg::instr_u i_instruction,
	pat_exec_if.decode exec
);

	// ==============================
	// encoding split
	// ==============================

	logic is_i8;
	logic is_i3;
	logic is_i0;
	logic [3:0] op8;
	logic [3:0] op3;
	logic [3:0] op0;

	assign op8 = i_instruction.i8.opcode;
	assign op3 = i_instruction.short.sub_op;
	assign op0 = i_instruction.short.low;

	assign is_i8 = (op8 != `PAT_PREFIX); // escape value opens i3 space
	assign is_i3 = !is_i8 && (op3 != `PAT_PREFIX);
	assign is_i0 = !is_i8 && !is_i3; // double escape

	// ==============================
	// opcode decode
	// ==============================

	pat_uop_pkg::alu_op_e d_alu_op;
	pat_uop_pkg::res_src_e d_res_src;
	logic [`PAT_D_WIDTH-1:0] d_imm;
	logic d_operand_mem;
	logic d_wr_acc;
	logic d_wr_mem;
	logic d_wr_out;
	logic d_do_test;
	logic d_br_fwd;
	logic d_br_back;

	// i3 carries only a shift amount, zero-extended
	assign d_imm = is_i8 ? i_instruction.i8.imm :
		{{(`PAT_D_WIDTH-`PAT_SHAMT_WIDTH){1'b0}}, op0[`PAT_SHAMT_WIDTH-1:0]};

	always_comb
	begin
		// anything unmatched falls out as a nop
		d_alu_op = pat_uop_pkg::ALU_OR;
		d_res_src = pat_uop_pkg::SRC_ALU;
		d_operand_mem = 1'b0;
		d_wr_acc = 1'b0;
		d_wr_mem = 1'b0;
		d_wr_out = 1'b0;
		d_do_test = 1'b0;
		d_br_fwd = 1'b0;
		d_br_back = 1'b0;
		if (is_i8)
		begin
			case (op8)
				pat_isa_pkg::OP8_OR, pat_isa_pkg::OP8_ORM: d_alu_op = pat_uop_pkg::ALU_OR;
				pat_isa_pkg::OP8_AND, pat_isa_pkg::OP8_ANDM: d_alu_op = pat_uop_pkg::ALU_AND;
				pat_isa_pkg::OP8_ADD, pat_isa_pkg::OP8_ADDM: d_alu_op = pat_uop_pkg::ALU_ADD;
				pat_isa_pkg::OP8_SUB, pat_isa_pkg::OP8_SUBM: d_alu_op = pat_uop_pkg::ALU_SUB;
				pat_isa_pkg::OP8_LDI, pat_isa_pkg::OP8_LDM: d_res_src = pat_uop_pkg::SRC_IMM;
				default: d_alu_op = pat_uop_pkg::ALU_OR; // no write follows
			endcase
			// memory forms read the word at imm[4:0]
			d_operand_mem = op8 inside {pat_isa_pkg::OP8_ADDM, pat_isa_pkg::OP8_SUBM,
				pat_isa_pkg::OP8_LDM, pat_isa_pkg::OP8_ORM, pat_isa_pkg::OP8_ANDM};
			d_wr_acc = op8 inside {pat_isa_pkg::OP8_OR, pat_isa_pkg::OP8_AND,
				pat_isa_pkg::OP8_ADDM, pat_isa_pkg::OP8_SUBM, pat_isa_pkg::OP8_ADD,
				pat_isa_pkg::OP8_SUB, pat_isa_pkg::OP8_LDI, pat_isa_pkg::OP8_LDM,
				pat_isa_pkg::OP8_ORM, pat_isa_pkg::OP8_ANDM};
			d_wr_mem = (op8 == pat_isa_pkg::OP8_STAM);
			d_br_fwd = (op8 == pat_isa_pkg::OP8_BF);
			d_br_back = (op8 == pat_isa_pkg::OP8_BB);
		end
		else if (is_i3)
		begin
			case (op3)
				pat_isa_pkg::OP3_SHL: d_alu_op = pat_uop_pkg::ALU_SHL;
				pat_isa_pkg::OP3_SHLO: d_alu_op = pat_uop_pkg::ALU_SHLO;
				pat_isa_pkg::OP3_SHR: d_alu_op = pat_uop_pkg::ALU_SHR;
				pat_isa_pkg::OP3_ASR: d_alu_op = pat_uop_pkg::ALU_ASR;
				pat_isa_pkg::OP3_IN: d_res_src = pat_uop_pkg::SRC_IN;
				default: d_alu_op = pat_uop_pkg::ALU_OR;
			endcase
			d_wr_acc = op3 inside {pat_isa_pkg::OP3_SHL, pat_isa_pkg::OP3_SHLO,
				pat_isa_pkg::OP3_SHR, pat_isa_pkg::OP3_ASR, pat_isa_pkg::OP3_IN};
			d_wr_out = (op3 == pat_isa_pkg::OP3_OUT);
		end
		else if (is_i0)
		begin
			d_alu_op = pat_uop_pkg::ALU_NOT; // only not writes back
			d_wr_acc = (op0 == pat_isa_pkg::OP0_NOT);
			d_do_test = (op0 == pat_isa_pkg::OP0_TEST);
		end
	end

	// ==============================
	// stage register
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset)
			exec.valid <= 1'b0;
		else
			exec.valid <= i_instr_valid; // no stall, one strobe in, one out
	end

	// bundle only matters while valid is high
	always_ff @(posedge clk)
	begin
		exec.cond <= i_instruction.i8.cond; // same bits in every view
		exec.alu_op <= d_alu_op;
		exec.res_src <= d_res_src;
		exec.operand_mem <= d_operand_mem;
		exec.imm <= d_imm;
		exec.wr_acc <= d_wr_acc;
		exec.wr_mem <= d_wr_mem;
		exec.wr_out <= d_wr_out;
		exec.do_test <= d_do_test;
		exec.br_fwd <= d_br_fwd;
		exec.br_back <= d_br_back;
	end

endmodule

`default_nettype wire

// File: src/pat_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_execute (
	input logic clk,
	input logic reset,
	pat_exec_if.execute exec,
	input logic [`PAT_D_WIDTH-1:0] i_inputs,
	output logic [`PAT_D_WIDTH-1:0] o_acc,
	output logic [`PAT_D_WIDTH-1:0] o_outputs,
	output logic o_retire
);

	logic z; // zero flag, test only
	logic n; // negative flag, test only
	logic commit;
	logic [`PAT_D_WIDTH-1:0] mem_rd_data;
	logic [`PAT_D_WIDTH-1:0] operand_b;
	logic [`PAT_D_WIDTH-1:0] alu_y;
	logic [`PAT_D_WIDTH-1:0] result;

	// ==============================
	// condition
	// ==============================

	always_comb
	begin
		case (exec.cond)
			pat_isa_pkg::COND_ZERO: exec.taken = z;
			pat_isa_pkg::COND_NEG: exec.taken = n;
			default: exec.taken = 1'b1; // 2 and 3 both mean always
		endcase
	end

	assign commit = exec.valid && exec.taken;

	// ==============================
	// operands and result
	// ==============================

	assign operand_b = exec.operand_mem ? mem_rd_data : exec.imm;

	pat_alu alu_inst (
		.i_a(o_acc),
		.i_b(operand_b),
		.i_op(exec.alu_op),
		.o_y(alu_y)
	);

	always_comb
	begin
		case (exec.res_src)
			pat_uop_pkg::SRC_IMM: result = operand_b; // ldi and ldm
			pat_uop_pkg::SRC_IN: result = i_inputs;
			default: result = alu_y;
		endcase
	end

	// read and write share the immediate address
	pat_data_mem dmem_inst (
		.clk(clk),
		.i_rd_adr(exec.imm[`PAT_DMEM_ADR_WIDTH-1:0]),
		.i_wr_adr(exec.imm[`PAT_DMEM_ADR_WIDTH-1:0]),
		.i_wr_en(commit && exec.wr_mem), // stam
		.i_wr_data(o_acc),
		.o_rd_data(mem_rd_data)
	);

	// ==============================
	// commit
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			o_outputs <= '0;
			z <= 1'b0;
			n <= 1'b0;
			o_retire <= 1'b0;
		end
		else
		begin
			o_retire <= exec.valid; // retire even when not taken
			if (commit)
			begin
				if (exec.wr_acc)
					o_acc <= result;
				if (exec.wr_out)
					o_outputs <= o_acc; // out sends the old acc
				if (exec.do_test)
				begin
					z <= (o_acc == '0);
					n <= o_acc[`PAT_D_WIDTH-1];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/pat_program_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_program_counter (
	input logic clk,
	input logic reset,
	pat_exec_if.pc exec,
	output logic [`PAT_PC_WIDTH-1:0] o_pc
);

	localparam logic [`PAT_PC_WIDTH-1:0] PC_STEP = 1;

	logic [`PAT_PC_WIDTH-1:0] offset;
	logic [`PAT_PC_WIDTH-1:0] pc_next;

	// unsigned branch distance
	assign offset = {{(`PAT_PC_WIDTH-`PAT_D_WIDTH){1'b0}}, exec.imm};

	always_comb
	begin
		if (exec.taken && exec.br_fwd)
			pc_next = o_pc + offset; // wraps at 1024
		else if (exec.taken && exec.br_back)
			pc_next = o_pc - offset;
		else
			pc_next = o_pc + PC_STEP; // includes failed branches
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (exec.valid)
			o_pc <= pc_next;
	end

endmodule

`default_nettype wire

// File: src/pat_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_core (
	input logic clk,
	input logic reset,
	input logic i_instr_valid,
	input logic [`PAT_I_WIDTH-1:0] i_instruction,
	input logic [`PAT_D_WIDTH-1:0] i_inputs,
	output logic [`PAT_PC_WIDTH-1:0] o_pc,
	output logic [`PAT_D_WIDTH-1:0] o_acc,
	output logic [`PAT_D_WIDTH-1:0] o_outputs,
	output logic o_retire
);

	// decoded bundle, decode to execute and pc
	pat_exec_if exec_bus ();

	pat_decoder decoder_inst (
		.clk(clk),
		.reset(reset),
		.i_instr_valid(i_instr_valid),
		.i_instruction(i_instruction), // raw word, viewed as the union inside
		.exec(exec_bus)
	);

	pat_execute execute_inst (
		.clk(clk),
		.reset(reset),
		.exec(exec_bus),
		.i_inputs(i_inputs),
		.o_acc(o_acc),
		.o_outputs(o_outputs),
		.o_retire(o_retire)
	);

	pat_program_counter pc_inst (
		.clk(clk),
		.reset(reset),
		.exec(exec_bus), // steps in the same edge as the commit
		.o_pc(o_pc)
	);

endmodule

`default_nettype wire

// File: tb/pat_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pat_defines.svh"

module pat_core_tb;

	localparam int N_RANDOM = 3000; // random phase length
	localparam int DRAIN_LIMIT = 20; // cycles allowed for the last retires

	// weighted mixes, a repeated entry raises its odds
	localparam logic [3:0] MIX8 [16] = '{pat_isa_pkg::OP8_OR, pat_isa_pkg::OP8_AND,
		pat_isa_pkg::OP8_ADDM, pat_isa_pkg::OP8_SUBM, pat_isa_pkg::OP8_ADD,
		pat_isa_pkg::OP8_SUB, pat_isa_pkg::OP8_LDI, pat_isa_pkg::OP8_LDI,
		pat_isa_pkg::OP8_LDM, pat_isa_pkg::OP8_BF, pat_isa_pkg::OP8_BB,
		pat_isa_pkg::OP8_STAM, pat_isa_pkg::OP8_STAM, pat_isa_pkg::OP8_ORM,
		pat_isa_pkg::OP8_ANDM, pat_isa_pkg::OP8_ADD};
	localparam logic [3:0] MIX3 [8] = '{pat_isa_pkg::OP3_SHL, pat_isa_pkg::OP3_SHLO,
		pat_isa_pkg::OP3_SHR, pat_isa_pkg::OP3_ASR, pat_isa_pkg::OP3_IN,
		pat_isa_pkg::OP3_OUT, pat_isa_pkg::OP3_OUT, pat_isa_pkg::OP3_ASR};
	localparam logic [3:0] MIX0 [4] = '{pat_isa_pkg::OP0_NOT, pat_isa_pkg::OP0_TEST,
		pat_isa_pkg::OP0_TEST, pat_isa_pkg::OP0_NOP};
	localparam logic [1:0] MIX_COND [8] = '{pat_isa_pkg::COND_ZERO, pat_isa_pkg::COND_NEG,
		2'd2, pat_isa_pkg::COND_ALWAYS, pat_isa_pkg::COND_ALWAYS, pat_isa_pkg::COND_ALWAYS,
		pat_isa_pkg::COND_ALWAYS, pat_isa_pkg::COND_ALWAYS};

	logic clk;
	logic reset;
	logic i_instr_valid;
	logic [`PAT_I_WIDTH-1:0] i_instruction;
	logic [`PAT_D_WIDTH-1:0] i_inputs;
	logic [`PAT_PC_WIDTH-1:0] o_pc;
	logic [`PAT_D_WIDTH-1:0] o_acc;
	logic [`PAT_D_WIDTH-1:0] o_outputs;
	logic o_retire;

	// reference model state
	logic [`PAT_D_WIDTH-1:0] m_acc;
	logic [`PAT_D_WIDTH-1:0] m_out;
	logic m_z;
	logic m_n;
	logic [`PAT_PC_WIDTH-1:0] m_pc;
	logic [`PAT_D_WIDTH-1:0] m_mem [`PAT_DMEM_DEPTH];

	logic sent_d1; // sent one falling edge ago
	logic sent_d2; // sent two falling edges ago, retires now
	logic [`PAT_I_WIDTH-1:0] pend_instr;
	int sent_count;
	int retire_count;

	pat_core pat_core_inst (
		.clk(clk),
		.reset(reset),
		.i_instr_valid(i_instr_valid),
		.i_instruction(i_instruction),
		.i_inputs(i_inputs),
		.o_pc(o_pc),
		.o_acc(o_acc),
		.o_outputs(o_outputs),
		.o_retire(o_retire)
	);

	always #20 clk = ~clk; // 40 ns period

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [`PAT_I_WIDTH-1:0] encode_i8(input logic [1:0] cond,
		input logic [3:0] op, input logic [7:0] imm);
		return {5'd0, cond, 1'b0, op, imm};
	endfunction

	// ==============================
	// reference model
	// ==============================

	task automatic apply_model(input logic [`PAT_I_WIDTH-1:0] ins, input logic [7:0] inputs);
		logic [3:0] op8;
		logic [3:0] op3;
		logic [3:0] op0;
		logic [7:0] imm;
		logic [7:0] b;
		logic [2:0] amt;
		logic taken;
		logic [8:0] fill;
		logic [15:0] wide;
		logic [`PAT_PC_WIDTH-1:0] next_pc;
		op8 = ins[11:8];
		op3 = ins[7:4];
		op0 = ins[3:0];
		imm = ins[7:0];
		amt = ins[2:0]; // i3 amount
		b = m_mem[imm[4:0]]; // memory operand
		fill = (9'd1 << amt) - 9'd1; // ones for shlo
		wide = {{8{m_acc[7]}}, m_acc} >> amt; // sign copies for asr
		next_pc = m_pc + 10'd1;
		case (ins[14:13])
			pat_isa_pkg::COND_ZERO: taken = m_z;
			pat_isa_pkg::COND_NEG: taken = m_n;
			default: taken = 1'b1;
		endcase
		if (!taken)
			next_pc = m_pc + 10'd1; // skipped, only the pc moves
		else if (op8 != `PAT_PREFIX)
			case (op8)
				pat_isa_pkg::OP8_OR: m_acc = m_acc | imm;
				pat_isa_pkg::OP8_AND: m_acc = m_acc & imm;
				pat_isa_pkg::OP8_ADD: m_acc = m_acc + imm;
				pat_isa_pkg::OP8_SUB: m_acc = m_acc - imm;
				pat_isa_pkg::OP8_ORM: m_acc = m_acc | b;
				pat_isa_pkg::OP8_ANDM: m_acc = m_acc & b;
				pat_isa_pkg::OP8_ADDM: m_acc = m_acc + b;
				pat_isa_pkg::OP8_SUBM: m_acc = m_acc - b;
				pat_isa_pkg::OP8_LDI: m_acc = imm;
				pat_isa_pkg::OP8_LDM: m_acc = b;
				pat_isa_pkg::OP8_STAM: m_mem[imm[4:0]] = m_acc;
				pat_isa_pkg::OP8_BF: next_pc = m_pc + {2'b00, imm};
				pat_isa_pkg::OP8_BB: next_pc = m_pc - {2'b00, imm};
				default: next_pc = m_pc + 10'd1; // unassigned, acts as nop
			endcase
		else if (op3 != `PAT_PREFIX)
			case (op3)
				pat_isa_pkg::OP3_SHL: m_acc = m_acc << amt;
				pat_isa_pkg::OP3_SHLO: m_acc = (m_acc << amt) | fill[7:0];
				pat_isa_pkg::OP3_SHR: m_acc = m_acc >> amt;
				pat_isa_pkg::OP3_ASR: m_acc = wide[7:0];
				pat_isa_pkg::OP3_IN: m_acc = inputs;
				pat_isa_pkg::OP3_OUT: m_out = m_acc;
				default: next_pc = m_pc + 10'd1;
			endcase
		else if (op0 == pat_isa_pkg::OP0_NOT)
			m_acc = ~m_acc;
		else if (op0 == pat_isa_pkg::OP0_TEST)
		begin
			m_z = (m_acc == 8'd0);
			m_n = m_acc[7];
		end
		m_pc = next_pc;
	endtask

	// ==============================
	// stimulus
	// ==============================

	task automatic pick_instruction(output logic [`PAT_I_WIDTH-1:0] ins);
		logic [31:0] r;
		logic [31:0] junk;
		logic [1:0] cond;
		r = $urandom();
		junk = $urandom(); // unused fields and immediates
		cond = MIX_COND[r[2:0]];
		if (r[31:24] < 8'd128) // about half are i8
			ins = {junk[4:0], cond, junk[5], MIX8[r[6:3]], junk[15:8]};
		else if (r[31:24] < 8'd208)
			ins = {junk[4:0], cond, junk[5], `PAT_PREFIX, MIX3[r[9:7]], junk[19:16]};
		else
			ins = {junk[4:0], cond, junk[5], `PAT_PREFIX, `PAT_PREFIX, MIX0[r[11:10]]};
	endtask

	// one falling edge: check, update model, drive next
	task automatic cycle_step(input logic send, input logic [`PAT_I_WIDTH-1:0] ins);
		logic [31:0] r;
		@(negedge clk);
		check_value("o_retire", 32'(o_retire), 32'(sent_d2));
		check_value("o_acc", 32'(o_acc), 32'(m_acc));
		check_value("o_outputs", 32'(o_outputs), 32'(m_out));
		check_value("o_pc", 32'(o_pc), 32'(m_pc));
		if (o_retire)
			retire_count++;
		r = $urandom();
		i_inputs = r[7:0]; // seen by the commit at the next rising edge
		if (sent_d1)
			apply_model(pend_instr, i_inputs);
		sent_d2 = sent_d1;
		sent_d1 = send;
		pend_instr = ins;
		i_instr_valid = send;
		i_instruction = ins; // random even when idle
		if (send)
			sent_count++;
	endtask

	initial
	begin
		logic [`PAT_I_WIDTH-1:0] ins;
		logic [31:0] r;
		int wait_cycles;
		void'($urandom(32'h30fdd3e0));
		clk = 1'b0;
		reset = 1'b1;
		i_instr_valid = 1'b0;
		i_instruction = '0;
		i_inputs = '0;
		m_acc = '0;
		m_out = '0;
		m_z = 1'b0;
		m_n = 1'b0;
		m_pc = '0;
		sent_d1 = 1'b0;
		sent_d2 = 1'b0;
		pend_instr = '0;
		sent_count = 0;
		retire_count = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_value("o_pc", 32'(o_pc), 32'd0); // reset values
		check_value("o_acc", 32'(o_acc), 32'd0);
		check_value("o_outputs", 32'(o_outputs), 32'd0);
		check_value("o_retire", 32'(o_retire), 32'd0);
		reset = 1'b0;

		// fill every memory word with a known value
		for (int a = 0; a < `PAT_DMEM_DEPTH; a++)
		begin
			r = $urandom();
			cycle_step(1'b1, encode_i8(pat_isa_pkg::COND_ALWAYS, pat_isa_pkg::OP8_LDI, r[7:0]));
			cycle_step(1'b1, encode_i8(pat_isa_pkg::COND_ALWAYS, pat_isa_pkg::OP8_STAM,
				{3'd0, a[4:0]}));
		end

		// negative acc, then one true and one false conditional
		cycle_step(1'b1, encode_i8(pat_isa_pkg::COND_ALWAYS, pat_isa_pkg::OP8_LDI, 8'h80));
		cycle_step(1'b1, {5'd0, pat_isa_pkg::COND_ALWAYS, 1'b0, `PAT_PREFIX, `PAT_PREFIX,
			pat_isa_pkg::OP0_TEST});
		cycle_step(1'b1, encode_i8(pat_isa_pkg::COND_NEG, pat_isa_pkg::OP8_LDI, 8'h11));
		cycle_step(1'b1, encode_i8(pat_isa_pkg::COND_ZERO, pat_isa_pkg::OP8_LDI, 8'h22));

		for (int i = 0; i < N_RANDOM; i++)
		begin
			r = $urandom();
			pick_instruction(ins);
			cycle_step(r[1:0] != 2'b00, ins); // about a quarter of cycles idle
		end

		wait_cycles = 0;
		while (retire_count < sent_count)
		begin
			if (wait_cycles == DRAIN_LIMIT)
			begin
				$display("timeout: only %0d of %0d instructions retired", retire_count,
					sent_count);
				$display("CHECKS FAILED");
				$fatal(1);
			end
			pick_instruction(ins);
			cycle_step(1'b0, ins);
			wait_cycles++;
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
src/pat_isa_pkg.sv
src/pat_uop_pkg.sv
src/pat_exec_if.sv
src/pat_alu.sv
src/pat_data_mem.sv
src/pat_decoder.sv
src/pat_execute.sv
src/pat_program_counter.sv
src/pat_core.sv
tb/pat_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module pat_core_tb -o Vpat_core_tb
./obj_dir/Vpat_core_tb 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
